// File: build.f
+incdir+include
hw/mips_pkg.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/execute_stage.sv
hw/exec_core.sv
testbench/exec_core_tb.sv

// File: Bender.yml
package:
  name: mips_exec_core

sources:
  - hw/mips_pkg.sv
  - hw/reg_file.sv
  - hw/instr_decode.sv
  - hw/execute_stage.sv
  - hw/exec_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/exec_core_tb.sv

// File: include/tb_ref_model.svh
//==========================================================================
// testbench reference model
// mips instruction encoders and a reference alu for the shadow registers
//==========================================================================
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// supported codes taken from the mips32 opcode map
localparam logic [5:0] r_functs [9] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                                        6'h27, 6'h2a, 6'h00, 6'h02};
localparam logic [5:0] i_ops [6] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

function automatic word_t enc_r(input logic [5:0] funct, input reg_addr_t rs,
                                input reg_addr_t rt, input reg_addr_t rd,
                                input shamt_t shamt);
   return {6'h00, rs, rt, rd, shamt, funct};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
                                input reg_addr_t rt, input logic [15:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic bit is_known(input word_t ins);
   bit hit;
   hit = 1'b0;
   if (ins[31:26] == 6'h00) begin
      foreach (r_functs[i])
         if (r_functs[i] == ins[5:0])
            hit = 1'b1;
   end else begin
      foreach (i_ops[i])
         if (i_ops[i] == ins[31:26])
            hit = 1'b1;
   end
   return hit;
endfunction

// r-type writes rd, i-type writes rt
function automatic reg_addr_t dest_of(input word_t ins);
   return (ins[31:26] == 6'h00) ? ins[15:11] : ins[20:16];
endfunction

// differing signs decide it, else plain unsigned order
function automatic word_t lt_signed(input word_t a, input word_t b);
   if (a[31] != b[31])
      return {31'd0, a[31]};
   return {31'd0, a < b};
endfunction

// a is the rs value, b the rt value
function automatic word_t ref_alu(input word_t ins, input word_t a, input word_t b);
   logic [15:0] imm;
   word_t       sx;
   word_t       zx;
   word_t       r;
   imm = ins[15:0];
   sx  = {{16{imm[15]}}, imm};
   zx  = {16'h0000, imm};
   r   = '0;
   case (ins[31:26])
      6'h00: begin
         case (ins[5:0])
            6'h21: r = a + b;
            6'h23: r = a - b;
            6'h24: r = a & b;
            6'h25: r = a | b;
            6'h26: r = a ^ b;
            6'h27: r = ~(a | b);
            6'h2a: r = lt_signed(a, b);
            6'h00: r = b << ins[10:6];
            6'h02: r = b >> ins[10:6];
            default: r = '0;
         endcase
      end
      6'h09: r = a + sx;
      6'h0a: r = lt_signed(a, sx);   // compare against sign-extended imm
      6'h0c: r = a & zx;
      6'h0d: r = a | zx;
      6'h0e: r = a ^ zx;
      6'h0f: r = {imm, 16'h0000};
      default: r = '0;
   endcase
   return r;
endfunction

`endif

// File: testbench/exec_core_tb.sv
//==========================================================================
// exec_core testbench
// directed and random instruction streams against a shadow register model,
// checked by concurrent assertions on wb, illegal and the host read port
//==========================================================================
`timescale 1ns/100ps

module exec_core_tb;
   import mips_pkg::*;
   `include "tb_ref_model.svh"

   localparam int clk_period  = 40;
   localparam int drive_delay = 2;             // ns after rising edge
   localparam int alu_per_op  = 8;
   localparam int chain_len   = 24;
   localparam int zero_count  = 8;
   localparam int bad_count   = 10;
   localparam int prog_len    = 64;
   localparam int num_tests   = 6;
   localparam int sweep_len   = num_regs + 2;  // drain plus one read per reg
   // fill, every test, four sweeps, one drain per test and reset
   localparam int total_slots = 2 * (num_regs - 1) + 15 * alu_per_op + chain_len + 1
                              + 2 * zero_count + bad_count + prog_len + 4 * sweep_len
                              + num_tests + 4;
   localparam int watchdog_ns = (total_slots + 50) * clk_period;

   logic      clk;
   logic      rst;
   word_t     instr;
   logic      instr_valid;
   reg_addr_t dbg_addr;
   wb_t       wb;
   logic      illegal;
   word_t     dbg_data;

   word_t     shadow [num_regs];  // architectural state in program order
   logic      pend_valid;         // expectation for the instruction driven now
   reg_addr_t pend_addr;
   word_t     pend_data;
   logic      pend_illegal;
   logic      exp_valid;          // one edge later, lined up with wb
   reg_addr_t exp_addr;
   word_t     exp_data;
   logic      exp_illegal;
   logic      dbg_check;          // dbg_data compared on next edge
   word_t     dbg_exp;

   string     test_name;
   int        errors;
   int        errors_base;        // count at test start
   int        n_tests;
   int        n_instr;

   exec_core dut (
      .clk         (clk),
      .rst         (rst),
      .instr       (instr),
      .instr_valid (instr_valid),
      .dbg_addr    (dbg_addr),
      .wb          (wb),
      .illegal     (illegal),
      .dbg_data    (dbg_data)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      if (rst) begin
         exp_valid   <= 1'b0;
         exp_illegal <= 1'b0;
      end else begin
         exp_valid   <= pend_valid;
         exp_illegal <= pend_illegal;
      end
      exp_addr <= pend_addr;
      exp_data <= pend_data;
   end

   a_wb_data : assert property (@(posedge clk) disable iff (rst)
      exp_valid |-> (wb.valid && (wb.addr == exp_addr) && (wb.data == exp_data)))
   else begin
      errors++;
      $display("MISMATCH %s wb: expected addr %0d data %08h, actual valid %0b addr %0d data %08h",
               test_name, $sampled(exp_addr), $sampled(exp_data),
               $sampled(wb.valid), $sampled(wb.addr), $sampled(wb.data));
   end

   // r0 targets, illegal words and idle cycles
   a_wb_quiet : assert property (@(posedge clk) disable iff (rst)
      !exp_valid |-> !wb.valid)
   else begin
      errors++;
      $display("MISMATCH %s wb.valid: expected 0, actual 1", test_name);
   end

   a_illegal : assert property (@(posedge clk) disable iff (rst)
      illegal == exp_illegal)
   else begin
      errors++;
      $display("MISMATCH %s illegal: expected %0b, actual %0b",
               test_name, $sampled(exp_illegal), $sampled(illegal));
   end

   a_dbg : assert property (@(posedge clk) disable iff (rst)
      dbg_check |-> (dbg_data == dbg_exp))
   else begin
      errors++;
      $display("MISMATCH %s dbg r%0d: expected %08h, actual %08h",
               test_name, $sampled(dbg_addr), $sampled(dbg_exp), $sampled(dbg_data));
   end

   task automatic step();
      @(posedge clk);
      #(drive_delay);
   endtask

   // strobe one word, model it, advance shadow state at once
   task automatic issue(input word_t ins);
      reg_addr_t dst;
      logic      legal;
      dst          = dest_of(ins);
      legal        = is_known(ins);
      instr        = ins;
      instr_valid  = 1'b1;
      pend_valid   = legal && (dst != '0);
      pend_addr    = dst;
      pend_data    = ref_alu(ins, shadow[ins[25:21]], shadow[ins[20:16]]);
      pend_illegal = !legal;
      if (pend_valid)
         shadow[dst] = pend_data;
      n_instr++;
      step();
   endtask

   task automatic idle();
      instr        = $urandom;  // noise, not strobed
      instr_valid  = 1'b0;
      pend_valid   = 1'b0;
      pend_illegal = 1'b0;
      step();
   endtask

   // let writes land, then walk the host port over every register
   task automatic sweep();
      idle();
      idle();
      for (int i = 0; i < num_regs; i++) begin
         dbg_addr  = reg_addr_t'(i);
         dbg_exp   = shadow[i];
         dbg_check = 1'b1;
         idle();
      end
      dbg_check = 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      errors_base = errors;
   endtask

   task automatic end_test();
      idle();  // last wb of the test lands on this edge
      n_tests++;
      $display("test %s done, %0d errors", test_name, errors - errors_base);
   endtask

   function automatic reg_addr_t rand_reg();  // never r0
      return reg_addr_t'($urandom_range(31, 1));
   endfunction

   // k picks one of the 15 supported ops, r-type first
   function automatic word_t make_op(input int unsigned k, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t dst);
      if (k < 9)
         return enc_r(r_functs[k], rs, rt, dst, shamt_t'($urandom));
      return enc_i(i_ops[k - 9], rs, dst, 16'($urandom));
   endfunction

   initial begin
      reg_addr_t src;
      reg_addr_t dst;
      word_t     bad;
      void'($urandom(32'h47677119));
      rst          = 1'b1;
      instr        = '0;
      instr_valid  = 1'b0;
      dbg_addr     = '0;
      pend_valid   = 1'b0;
      pend_addr    = '0;
      pend_data    = '0;
      pend_illegal = 1'b0;
      dbg_check    = 1'b0;
      dbg_exp      = '0;
      errors       = 0;
      n_tests      = 0;
      n_instr      = 0;
      test_name    = "reset";
      foreach (shadow[i])
         shadow[i] = '0;
      repeat (4) @(posedge clk);
      #(drive_delay);
      rst = 1'b0;

      start_test("reset");
      sweep();
      end_test();

      start_test("alu_ops");
      for (int r = 1; r < num_regs; r++) begin
         issue(enc_i(6'h0f, 5'd0, reg_addr_t'(r), 16'($urandom)));          // lui
         issue(enc_i(6'h0d, reg_addr_t'(r), reg_addr_t'(r), 16'($urandom)));  // ori on it
      end
      for (int k = 0; k < 15; k++)
         repeat (alu_per_op)
            issue(make_op(k, rand_reg(), rand_reg(), rand_reg()));
      end_test();

      start_test("dependencies");
      dst = rand_reg();
      issue(enc_i(6'h09, 5'd0, dst, 16'($urandom)));
      for (int n = 0; n < chain_len; n++) begin
         src = dst;
         dst = rand_reg();
         issue(make_op($urandom_range(14, 0), src,
                       ($urandom_range(1, 0) != 0) ? src : rand_reg(), dst));
      end
      end_test();

      start_test("reg_zero");
      for (int n = 0; n < zero_count; n++) begin
         issue(make_op($urandom_range(14, 0), rand_reg(), rand_reg(), 5'd0));
         issue(make_op($urandom_range(14, 0), 5'd0, 5'd0, rand_reg()));  // r0 sources
      end
      sweep();
      end_test();

      start_test("illegal");
      for (int n = 0; n < bad_count; n++) begin
         do begin
            bad = $urandom;
            if (n % 2 == 0)
               bad[31:26] = 6'h00;  // special with unused funct
         end while (is_known(bad));
         issue(bad);
      end
      sweep();
      end_test();

      start_test("host_read");
      for (int n = 0; n < prog_len; n++)
         issue(make_op($urandom_range(14, 0), rand_reg(), rand_reg(),
                       reg_addr_t'($urandom)));
      sweep();
      end_test();

      $display("tests %0d, instructions %0d, errors %0d", n_tests, n_instr, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(watchdog_ns);
      $display("timeout, run did not finish within %0d ns", watchdog_ns);
      $display("Simulation failed");
      $finish;
   end

endmodule

// File: hw/exec_core.sv
//==========================================================================
// mips integer execute slice, top level
// decoder, register file and execute stage, two instructions in flight
//==========================================================================
`timescale 1ns/100ps

module exec_core (
   input  logic                clk,
   input  logic                rst,          // sync, active high
   input  mips_pkg::word_t     instr,
   input  logic                instr_valid,  // one-cycle strobe
   input  mips_pkg::reg_addr_t dbg_addr,
   output mips_pkg::wb_t       wb,           // result, one cycle after strobe
   output logic                illegal,
   output mips_pkg::word_t     dbg_data
);
   import mips_pkg::*;

   decoded_t dec;      // decode out, same cycle
   word_t    rs_data;
   word_t    rt_data;

   instr_decode u_decode (
      .instr_valid (instr_valid),
      .instr       (instr),
      .dec         (dec)
   );

   // write port is fed back from the wb register
   reg_file u_regs (
      .clk      (clk),
      .rst      (rst),
      .rs_addr  (dec.rs),
      .rt_addr  (dec.rt),
      .dbg_addr (dbg_addr),
      .wb       (wb),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .dbg_data (dbg_data)
   );

   execute_stage u_exec (
      .clk     (clk),
      .rst     (rst),
      .dec     (dec),
      .rs_data (rs_data),
      .rt_data (rt_data),
      .wb      (wb),
      .illegal (illegal)
   );

endmodule

// File: hw/execute_stage.sv
//==========================================================================
// execute stage, alu plus registered writeback
// one cycle from decode to wb, illegal flag rides the same stage
//==========================================================================
`timescale 1ns/100ps

module execute_stage (
   input  logic               clk,
   input  logic               rst,
   input  mips_pkg::decoded_t dec,
   input  mips_pkg::word_t    rs_data,  // operand a, bypassed
   input  mips_pkg::word_t    rt_data,
   output mips_pkg::wb_t      wb,       // valid for one cycle
   output logic               illegal   // pulse, one cycle after strobe
);
   import mips_pkg::*;

   word_t op_a;
   word_t op_b;    // rt or extended imm
   word_t result;

   assign op_a = rs_data;
   assign op_b = dec.use_imm ? dec.imm : rt_data;

   always_comb begin
      case (dec.op)
         ALU_ADD: result = op_a + op_b;   // wraps, no overflow trap
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         ALU_SLT: result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
         ALU_SLL: result = rt_data << dec.shamt;
         ALU_SRL: result = rt_data >> dec.shamt;   // logical
         ALU_LUI: result = {dec.imm[15:0], 16'h0000};
         default: result = '0;
      endcase
   end

   // payload follows decode each cycle, valid and illegal are cleared by reset
   always_ff @(posedge clk) begin
      wb.addr <= dec.rd;
      wb.data <= result;
      if (rst) begin
         wb.valid <= 1'b0;
         illegal  <= 1'b0;
      end else begin
         wb.valid <= dec.we;
         illegal  <= dec.illegal;
      end
   end

   // an illegal instruction must never reach the register file
   a_wb_not_illegal : assert property (
      @(posedge clk) disable iff (rst)
      !(wb.valid && illegal)
   ) else $error("writeback valid together with illegal");

endmodule

// File: hw/instr_decode.sv
//==========================================================================
// instruction decoder, combinational
// splits the word into fields, picks the alu op and extends the immediate
//==========================================================================
`timescale 1ns/100ps

module instr_decode (
   input  logic                 instr_valid,  // strobe, taken this edge
   input  mips_pkg::word_t      instr,
   output mips_pkg::decoded_t   dec
);
   import mips_pkg::*;

   opcode_t   opcode;    // bits 31:26
   funct_t    funct;     // bits 5:0
   word_t     imm_sext;  // addiu, slti
   word_t     imm_zext;  // andi, ori, xori, lui
   reg_addr_t dest;      // rd or rt
   logic      known;     // encoding in the supported set

   assign opcode   = opcode_t'(instr[31:26]);
   assign funct    = funct_t'(instr[5:0]);
   assign imm_sext = {{16{instr[15]}}, instr[15:0]};
   assign imm_zext = {16'h0000, instr[15:0]};

   always_comb begin
      dec       = '0;
      dec.rs    = instr[25:21];
      dec.rt    = instr[20:16];
      dec.shamt = instr[10:6];
      dec.op    = ALU_ADD;
      dec.imm   = imm_sext;
      known     = 1'b1;
      dest      = instr[15:11];  // r-type default

      case (opcode)
         OP_SPECIAL: begin
            case (funct)
               F_ADDU:  dec.op = ALU_ADD;
               F_SUBU:  dec.op = ALU_SUB;
               F_AND:   dec.op = ALU_AND;
               F_OR:    dec.op = ALU_OR;
               F_XOR:   dec.op = ALU_XOR;
               F_NOR:   dec.op = ALU_NOR;
               F_SLT:   dec.op = ALU_SLT;
               F_SLL:   dec.op = ALU_SLL;
               F_SRL:   dec.op = ALU_SRL;
               default: known  = 1'b0;
            endcase
         end
         OP_ADDIU: dec.op = ALU_ADD;   // sign-extended imm
         OP_SLTI:  dec.op = ALU_SLT;
         OP_ANDI: begin
            dec.op  = ALU_AND;
            dec.imm = imm_zext;
         end
         OP_ORI: begin
            dec.op  = ALU_OR;
            dec.imm = imm_zext;
         end
         OP_XORI: begin
            dec.op  = ALU_XOR;
            dec.imm = imm_zext;
         end
         OP_LUI: begin
            dec.op  = ALU_LUI;
            dec.imm = imm_zext;        // shifted up in execute
         end
         default: known = 1'b0;
      endcase

      // every i-type writes rt and takes imm as operand b
      if (opcode != OP_SPECIAL) begin
         dest        = instr[20:16];
         dec.use_imm = 1'b1;
      end

      dec.rd      = dest;
      dec.illegal = instr_valid & ~known;
      dec.we      = instr_valid & known & (dest != '0);  // r0 writes dropped here
   end

endmodule

// File: hw/reg_file.sv
//==========================================================================
// 32x32 register file, two operand reads plus a host read port
// single gated write from writeback, r0 hardwired zero, write bypass
//==========================================================================
`timescale 1ns/100ps

module reg_file (
   input  logic                clk,
   input  logic                rst,       // sync, clears every register
   input  mips_pkg::reg_addr_t rs_addr,
   input  mips_pkg::reg_addr_t rt_addr,
   input  mips_pkg::reg_addr_t dbg_addr,  // host inspect index
   input  mips_pkg::wb_t       wb,        // write port
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data,
   output mips_pkg::word_t     dbg_data   // stored value only, no bypass
);
   import mips_pkg::*;

   word_t               regs [num_regs];  // register array
   logic [num_regs-1:0] we_sel;           // one-hot write select

   // write decoder, gated by wb.valid, r0 never selected
   always_comb begin
      we_sel = '0;
      if (wb.valid)
         we_sel[wb.addr] = 1'b1;
      we_sel[0] = 1'b0;
   end

   // one word per register, same shape for all 32
   for (genvar i = 0; i < num_regs; i++) begin : g_reg
      always_ff @(posedge clk) begin
         if (rst)
            regs[i] <= '0;
         else if (we_sel[i])
            regs[i] <= wb.data;
      end
   end

   // operand read with zero reg and bypass of the write in flight
   function automatic word_t read_port(input reg_addr_t addr);
      word_t val;
      if (addr == '0)
         val = '0;
      else if (wb.valid && (wb.addr == addr))
         val = wb.data;  // value lands on this same edge
      else
         val = regs[addr];
      return val;
   endfunction

   always_comb begin
      rs_data = read_port(rs_addr);
      rt_data = read_port(rt_addr);
   end

   assign dbg_data = regs[dbg_addr];  // raw array, r0 is zero by reset

   // decoder must never let a writeback aim at r0
   a_no_r0_write : assert property (
      @(posedge clk) disable iff (rst)
      wb.valid |-> (wb.addr != '0)
   ) else $error("writeback targets register 0");

endmodule

// File: hw/mips_pkg.sv
//==========================================================================
// mips integer execute slice, shared types
// word and index types, opcode and funct encodings, alu ops, stage structs
//==========================================================================
package mips_pkg;

   localparam int num_regs = 32;   // architectural register count

   typedef logic [31:0] word_t;      // data word
   typedef logic [4:0]  reg_addr_t;  // register index
   typedef logic [4:0]  shamt_t;     // shift amount field

   // primary opcodes in use, bits 31:26
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,  // r-type, op in funct
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f
   } opcode_t;

   // r-type function codes in use, bits 5:0
   typedef enum logic [5:0] {
      F_SLL  = 6'h00,
      F_SRL  = 6'h02,
      F_ADDU = 6'h21,
      F_SUBU = 6'h23,
      F_AND  = 6'h24,
      F_OR   = 6'h25,
      F_XOR  = 6'h26,
      F_NOR  = 6'h27,
      F_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,   // signed compare
      ALU_SLL,
      ALU_SRL,
      ALU_LUI    // imm into upper half
   } alu_op_t;

   // decoder output, one instruction
   typedef struct packed {
      reg_addr_t rs;       // source a
      reg_addr_t rt;       // source b
      reg_addr_t rd;       // destination, rt for i-type
      alu_op_t   op;
      word_t     imm;      // already extended
      shamt_t    shamt;
      logic      use_imm;  // b operand from imm
      logic      we;       // valid, legal, nonzero dest
      logic      illegal;  // valid but unknown encoding
   } decoded_t;

   // registered writeback
   typedef struct packed {
      logic      valid;
      reg_addr_t addr;
      word_t     data;
   } wb_t;

endpackage
